//--- logic/uart_pkg.sv
// uart shared definitions
// bus types, parity and FSM encodings, register map and parity helper

package uart_pkg;

    // APB byte address and data word
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } uart_parity_e;

    // FSM states of the receiver and the transmitter
    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP, RX_WAIT
    } uart_rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } uart_tx_state_e;

    localparam apb_addr_t REG_CTRL    = 4'h0;
    localparam apb_addr_t REG_DIVIDER = 4'h4;
    localparam apb_addr_t REG_STATUS  = 4'h8;

    // anything shorter leaves no room for the half-bit start check
    localparam int MIN_DIVIDER = 4;

    // data_xor is the XOR reduction of the data bits
    function automatic logic calc_parity(input logic data_xor, input uart_parity_e mode);
        logic odd;
        odd = (mode == PARITY_ODD);
        return data_xor ^ odd;
    endfunction

endpackage

//--- logic/uart_apb_regs.sv
// uart register block
// APB slave with control, divider and status registers, zero wait states
`timescale 1ns/1ps

module uart_apb_regs #(
    parameter int DIVIDER_WIDTH = 16,
    parameter int DIVIDER_RESET = 16
) (
    input  logic                     m_axis,
    input  logic                     rst_n_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  uart_pkg::apb_addr_t      paddr_i,
    input  uart_pkg::apb_data_t      pwdata_i,
    output uart_pkg::apb_data_t      prdata_o,
    input  logic                     tx_busy_i,
    input  logic                     rx_valid_i,
    input  logic                     parity_err_i,
    output uart_pkg::uart_parity_e   parity_o,
    output logic [DIVIDER_WIDTH-1:0] divider_o
);

    import uart_pkg::*;

    uart_parity_e             parity_q;
    logic [DIVIDER_WIDTH-1:0] divider_q;
    logic                     parity_err_q;
    logic                     wr_en;
    uart_parity_e             wr_parity;
    logic [DIVIDER_WIDTH-1:0] wr_divider;

    // a write lands at the edge that closes the access cycle
    assign wr_en = psel_i & penable_i & pwrite_i;

    // mode 3 is reserved and falls back to no parity
    assign wr_parity = (pwdata_i[1:0] == 2'd3) ? PARITY_NONE : uart_parity_e'(pwdata_i[1:0]);

    always_comb begin
        wr_divider = pwdata_i[DIVIDER_WIDTH-1:0];
        if (wr_divider < MIN_DIVIDER) begin
            wr_divider = DIVIDER_WIDTH'(MIN_DIVIDER);
        end
    end

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            parity_q  <= PARITY_NONE;
            divider_q <= DIVIDER_WIDTH'(DIVIDER_RESET);
        end else if (wr_en) begin
            if (paddr_i == REG_CTRL) begin
                parity_q <= wr_parity;
            end
            if (paddr_i == REG_DIVIDER) begin
                divider_q <= wr_divider;
            end
        end
    end

    // a new error beats a clear of the sticky flag in the same cycle
    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            parity_err_q <= 1'b0;
        end else if (parity_err_i) begin
            parity_err_q <= 1'b1;
        end else if (wr_en && (paddr_i == REG_STATUS) && pwdata_i[0]) begin
            parity_err_q <= 1'b0;
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            REG_CTRL: begin
                prdata_o[1:0] = parity_q;
            end
            REG_DIVIDER: begin
                prdata_o[DIVIDER_WIDTH-1:0] = divider_q;
            end
            REG_STATUS: begin
                prdata_o[2:0] = {rx_valid_i, tx_busy_i, parity_err_q};
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

    assign parity_o  = parity_q;
    assign divider_o = divider_q;

    // holds for the reset value and for every legalized write
    a_divider_min: assert property (
        @(posedge m_axis) disable iff (!rst_n_i)
        divider_o >= MIN_DIVIDER
    );

endmodule

//--- logic/uart_tx.sv
// uart transmitter
// serializes stream bytes into start, data, optional parity and stop bits
`timescale 1ns/1ps

module uart_tx #(
    parameter int DATA_WIDTH    = 8,
    parameter int DIVIDER_WIDTH = 16
) (
    input  logic                     m_axis,
    input  logic                     rst_n_i,
    input  uart_pkg::uart_parity_e   parity_i,
    input  logic [DIVIDER_WIDTH-1:0] divider_i,
    input  logic [DATA_WIDTH-1:0]    s_axis_tdata_i,
    input  logic                     s_axis_tvalid_i,
    output logic                     s_axis_tready_o,
    output logic                     uart_tx_o,
    output logic                     tx_busy_o
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    uart_tx_state_e           state;
    logic [DIVIDER_WIDTH-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]     bit_cnt;
    logic [DATA_WIDTH-1:0]    shift_q;
    logic                     par_bit_q;
    logic                     par_en_q;
    logic                     tx_q;
    logic                     accept;
    logic                     baud_done;
    logic                     bit_last;

    assign accept    = s_axis_tvalid_i & s_axis_tready_o;
    assign baud_done = (baud_cnt == divider_i - 1'b1);
    assign bit_last  = (bit_cnt == BIT_CNT_W'(DATA_WIDTH - 1));

    // the line level is registered with each transition
    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= TX_IDLE;
            bit_cnt  <= '0;
            par_en_q <= 1'b0;
            tx_q     <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        state    <= TX_START;
                        par_en_q <= (parity_i != PARITY_NONE);
                        tx_q     <= 1'b0;
                    end
                end
                TX_START: begin
                    if (baud_done) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        tx_q    <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (baud_done) begin
                        if (bit_last) begin
                            state <= par_en_q ? TX_PARITY : TX_STOP;
                            tx_q  <= par_en_q ? par_bit_q : 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_q    <= shift_q[1];
                        end
                    end
                end
                TX_PARITY: begin
                    if (baud_done) begin
                        state <= TX_STOP;
                        tx_q  <= 1'b1;
                    end
                end
                TX_STOP: begin
                    if (baud_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    tx_q  <= 1'b1;
                end
            endcase
        end
    end

    // byte and its parity bit are captured on acceptance
    always_ff @(posedge m_axis) begin
        if (accept) begin
            shift_q   <= s_axis_tdata_i;
            par_bit_q <= calc_parity(^s_axis_tdata_i, parity_i);
        end else if ((state == TX_DATA) && baud_done && !bit_last) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_cnt <= '0;
        end else if ((state == TX_IDLE) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign s_axis_tready_o = (state == TX_IDLE);
    assign tx_busy_o       = (state != TX_IDLE);
    assign uart_tx_o       = tx_q;

    a_idle_line_high: assert property (
        @(posedge m_axis) disable iff (!rst_n_i)
        (state == TX_IDLE) |-> uart_tx_o
    );

endmodule

//--- logic/uart_rx.sv
// uart receiver
// samples the line mid-bit, checks parity and presents good bytes on a stream port
`timescale 1ns/1ps

module uart_rx #(
    parameter int DATA_WIDTH    = 8,
    parameter int DIVIDER_WIDTH = 16
) (
    input  logic                     m_axis,
    input  logic                     rst_n_i,
    input  uart_pkg::uart_parity_e   parity_i,
    input  logic [DIVIDER_WIDTH-1:0] divider_i,
    input  logic                     uart_rx_i,
    output logic [DATA_WIDTH-1:0]    m_axis_tdata_o,
    output logic                     m_axis_tvalid_o,
    input  logic                     m_axis_tready_i,
    output logic                     parity_err_o
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    uart_rx_state_e           state;
    uart_parity_e             mode_q;
    logic [DIVIDER_WIDTH-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]     bit_cnt;
    logic [DATA_WIDTH-1:0]    rx_shift;
    logic                     parity_err_q;
    logic                     baud_done;
    logic                     bit_last;
    logic                     start_check;
    logic                     frame_ok;
    logic                     handshake;

    assign baud_done   = (baud_cnt == divider_i - 1'b1);
    assign bit_last    = (bit_cnt == BIT_CNT_W'(DATA_WIDTH - 1));
    assign start_check = (state == RX_START) && (baud_cnt == (divider_i >> 1) - 1'b1);
    assign frame_ok    = (state == RX_WAIT) && !parity_err_q;
    assign handshake   = m_axis_tvalid_o & m_axis_tready_i;

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= RX_IDLE;
            mode_q       <= PARITY_NONE;
            bit_cnt      <= '0;
            parity_err_q <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    mode_q       <= parity_i;
                    parity_err_q <= 1'b0;
                    if (!uart_rx_i) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // a line back high at half a bit was only a glitch
                    if (start_check) begin
                        state   <= uart_rx_i ? RX_IDLE : RX_DATA;
                        bit_cnt <= '0;
                    end
                end
                RX_DATA: begin
                    if (baud_done) begin
                        if (bit_last) begin
                            state <= (mode_q != PARITY_NONE) ? RX_PARITY : RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    if (baud_done) begin
                        state        <= RX_STOP;
                        parity_err_q <= (uart_rx_i != calc_parity(^rx_shift, mode_q));
                    end
                end
                RX_STOP: begin
                    if (baud_done) begin
                        state <= RX_WAIT;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, so bits enter at the top and move down
    always_ff @(posedge m_axis) begin
        if ((state == RX_DATA) && baud_done) begin
            rx_shift <= {uart_rx_i, rx_shift[DATA_WIDTH-1:1]};
        end
    end

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_cnt <= '0;
        end else if ((state == RX_IDLE) || (state == RX_WAIT) || baud_done || start_check) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // a frame finishing while the last byte is still pending is dropped
    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_axis_tvalid_o <= 1'b0;
        end else if (handshake) begin
            m_axis_tvalid_o <= 1'b0;
        end else if (frame_ok) begin
            m_axis_tvalid_o <= 1'b1;
        end
    end

    always_ff @(posedge m_axis) begin
        if (frame_ok && !m_axis_tvalid_o) begin
            m_axis_tdata_o <= rx_shift;
        end
    end

    assign parity_err_o = (state == RX_WAIT) && parity_err_q;

    a_hold_under_backpressure: assert property (
        @(posedge m_axis) disable iff (!rst_n_i)
        (m_axis_tvalid_o && !m_axis_tready_i) |=> (m_axis_tvalid_o && $stable(m_axis_tdata_o))
    );

endmodule

//--- logic/uart_top.sv
// uart peripheral top level
// ties the APB register block to the transmitter and the receiver
`timescale 1ns/1ps

module uart_top #(
    parameter int DATA_WIDTH    = 8,
    parameter int DIVIDER_WIDTH = 16,
    parameter int DIVIDER_RESET = 16
) (
    input  logic                  m_axis,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  uart_pkg::apb_addr_t   paddr_i,
    input  uart_pkg::apb_data_t   pwdata_i,
    output uart_pkg::apb_data_t   prdata_o,
    input  logic [DATA_WIDTH-1:0] s_axis_tdata_i,
    input  logic                  s_axis_tvalid_i,
    output logic                  s_axis_tready_o,
    output logic [DATA_WIDTH-1:0] m_axis_tdata_o,
    output logic                  m_axis_tvalid_o,
    input  logic                  m_axis_tready_i,
    output logic                  uart_tx_o,
    input  logic                  uart_rx_i
);

    import uart_pkg::*;

    uart_parity_e             parity;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic                     tx_busy;
    logic                     parity_err;

    uart_apb_regs #(
        .DIVIDER_WIDTH (DIVIDER_WIDTH),
        .DIVIDER_RESET (DIVIDER_RESET)
    ) u_regs (
        .m_axis       (m_axis),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .tx_busy_i    (tx_busy),
        .rx_valid_i   (m_axis_tvalid_o),
        .parity_err_i (parity_err),
        .parity_o     (parity),
        .divider_o    (divider)
    );

    uart_tx #(
        .DATA_WIDTH    (DATA_WIDTH),
        .DIVIDER_WIDTH (DIVIDER_WIDTH)
    ) u_tx (
        .m_axis          (m_axis),
        .rst_n_i         (rst_n_i),
        .parity_i        (parity),
        .divider_i       (divider),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .uart_tx_o       (uart_tx_o),
        .tx_busy_o       (tx_busy)
    );

    uart_rx #(
        .DATA_WIDTH    (DATA_WIDTH),
        .DIVIDER_WIDTH (DIVIDER_WIDTH)
    ) u_rx (
        .m_axis          (m_axis),
        .rst_n_i         (rst_n_i),
        .parity_i        (parity),
        .divider_i       (divider),
        .uart_rx_i       (uart_rx_i),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tready_i (m_axis_tready_i),
        .parity_err_o    (parity_err)
    );

endmodule

//--- sim/uart_tb.sv
// uart peripheral testbench
// register access, loopback streams, parity errors and receive back-pressure
`timescale 1ns/1ps

module uart_tb;

    import uart_pkg::*;

    localparam int DIV_TEST   = 8;
    localparam int WAIT_LIMIT = 4000;

    logic       m_axis;
    logic       rst_n_i;
    logic       psel_i;
    logic       penable_i;
    logic       pwrite_i;
    apb_addr_t  paddr_i;
    apb_data_t  pwdata_i;
    apb_data_t  prdata_o;
    logic [7:0] s_axis_tdata_i;
    logic       s_axis_tvalid_i;
    logic       s_axis_tready_o;
    logic [7:0] m_axis_tdata_o;
    logic       m_axis_tvalid_o;
    logic       m_axis_tready_i;
    logic       uart_tx_o;
    logic       uart_rx_i;
    logic       loopback;
    logic       bang_line;
    int         value_errs = 0;
    int         proto_errs = 0;
    int         timeout_errs = 0;

    // the receive line is either the transmitter or the bit-banger
    assign uart_rx_i = loopback ? uart_tx_o : bang_line;

    uart_top DUT (
        .m_axis          (m_axis),
        .rst_n_i         (rst_n_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tready_i (m_axis_tready_i),
        .uart_tx_o       (uart_tx_o),
        .uart_rx_i       (uart_rx_i)
    );

    initial begin
        m_axis = 1'b0;
        forever #10 m_axis = ~m_axis;
    end

    a_rx_hold: assert property (@(posedge m_axis) disable iff (!rst_n_i)
        (m_axis_tvalid_o && !m_axis_tready_i) |=> (m_axis_tvalid_o && $stable(m_axis_tdata_o)))
        else begin
            proto_errs++;
            $display("At %0t the held receive byte changed or was dropped under back-pressure",
                     $time);
        end

    // the start bit follows acceptance on the next cycle
    a_tx_start: assert property (@(posedge m_axis) disable iff (!rst_n_i)
        (s_axis_tvalid_i && s_axis_tready_o) |=> (!s_axis_tready_o && !uart_tx_o))
        else begin
            proto_errs++;
            $display("At %0t the transmitter did not start a frame after accepting a byte", $time);
        end

    task automatic check_value(input string name, input apb_data_t exp, input apb_data_t act);
        assert (act === exp) else begin
            value_errs++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errs++;
        $display("Timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        psel_i   = 1'b1;
        pwrite_i = 1'b1;
        paddr_i  = addr;
        pwdata_i = data;
        @(posedge m_axis);
        #1;
        penable_i = 1'b1;
        @(posedge m_axis);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        psel_i   = 1'b1;
        pwrite_i = 1'b0;
        paddr_i  = addr;
        @(posedge m_axis);
        #1;
        penable_i = 1'b1;
        data = prdata_o;
        @(posedge m_axis);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] data);
        int n;
        n = 0;
        s_axis_tdata_i  = data;
        s_axis_tvalid_i = 1'b1;
        while (!s_axis_tready_o && n < WAIT_LIMIT) begin
            @(posedge m_axis);
            #1;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_timeout("s_axis_tready_o");
        end
        @(posedge m_axis);
        #1;
        s_axis_tvalid_i = 1'b0;
    endtask

    task automatic recv_byte(output logic [7:0] data);
        int n;
        n = 0;
        while (!m_axis_tvalid_o && n < WAIT_LIMIT) begin
            @(posedge m_axis);
            #1;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_timeout("m_axis_tvalid_o");
        end
        data = m_axis_tdata_o;
        m_axis_tready_i = 1'b1;
        @(posedge m_axis);
        #1;
        m_axis_tready_i = 1'b0;
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (!s_axis_tready_o && n < WAIT_LIMIT) begin
            @(posedge m_axis);
            #1;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_timeout("the transmitter to go idle");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge m_axis);
            #1;
            check_value("m_axis_tvalid_o", 0, m_axis_tvalid_o);
        end
    endtask

    // with even parity the parity bit makes the number of ones even
    function automatic logic parity_bit(input logic [7:0] data, input uart_parity_e mode);
        if (mode == PARITY_ODD) begin
            return ~(^data);
        end
        return ^data;
    endfunction

    task automatic drive_bit(input logic b);
        bang_line = b;
        repeat (DIV_TEST) @(posedge m_axis);
        #1;
    endtask

    task automatic bang_frame(input logic [7:0] data, input uart_parity_e mode, input logic flip);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        if (mode != PARITY_NONE) begin
            drive_bit(parity_bit(data, mode) ^ flip);
        end
        drive_bit(1'b1);
    endtask

    task automatic loopback_run(input int count);
        logic [7:0] sent[$];
        logic [7:0] tx_byte;
        logic [7:0] got;
        apb_data_t  status;
        fork
            begin
                for (int i = 0; i < count; i++) begin
                    tx_byte = 8'($urandom() % 256);
                    sent.push_back(tx_byte);
                    send_byte(tx_byte);
                    apb_read(REG_STATUS, status);
                    check_value("STATUS[1] tx_busy", 1, status[1]);
                end
            end
            begin
                for (int j = 0; j < count; j++) begin
                    recv_byte(got);
                    check_value("m_axis_tdata_o", sent.pop_front(), got);
                end
            end
        join
        wait_tx_idle();
    endtask

    initial begin
        apb_data_t  rd;
        logic [7:0] b1;
        logic [7:0] got;
        void'($urandom(68));
        rst_n_i         = 1'b0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        s_axis_tdata_i  = '0;
        s_axis_tvalid_i = 1'b0;
        m_axis_tready_i = 1'b0;
        loopback        = 1'b1;
        bang_line       = 1'b1;
        repeat (2) @(posedge m_axis);
        #1;
        rst_n_i = 1'b1;

        check_value("uart_tx_o", 1, uart_tx_o);
        check_value("m_axis_tvalid_o", 0, m_axis_tvalid_o);
        check_value("s_axis_tready_o", 1, s_axis_tready_o);
        apb_read(REG_CTRL, rd);
        check_value("CTRL", 0, rd);
        apb_read(REG_DIVIDER, rd);
        check_value("DIVIDER", 16, rd);
        apb_read(REG_STATUS, rd);
        check_value("STATUS", 0, rd);

        apb_write(REG_CTRL, 32'd1);
        apb_read(REG_CTRL, rd);
        check_value("CTRL", 1, rd);
        apb_write(REG_CTRL, 32'd3);
        apb_read(REG_CTRL, rd);
        check_value("CTRL", 0, rd);
        apb_write(REG_DIVIDER, 32'd2);
        apb_read(REG_DIVIDER, rd);
        check_value("DIVIDER", 4, rd);
        apb_write(REG_DIVIDER, DIV_TEST);
        apb_read(REG_DIVIDER, rd);
        check_value("DIVIDER", DIV_TEST, rd);
        apb_read(4'hC, rd);
        check_value("unmapped", 0, rd);

        loopback_run(20);
        apb_write(REG_CTRL, PARITY_EVEN);
        loopback_run(8);
        apb_write(REG_CTRL, PARITY_ODD);
        loopback_run(8);
        apb_read(REG_STATUS, rd);
        check_value("STATUS[0] parity_err", 0, rd[0]);

        // a corrupted parity bit must drop the frame and flag the error
        loopback = 1'b0;
        apb_write(REG_CTRL, PARITY_EVEN);
        bang_frame(8'hA5, PARITY_EVEN, 1'b1);
        expect_quiet(2 * 11 * DIV_TEST);
        apb_read(REG_STATUS, rd);
        check_value("STATUS[0] parity_err", 1, rd[0]);
        apb_write(REG_STATUS, 32'd1);
        apb_read(REG_STATUS, rd);
        check_value("STATUS[0] parity_err", 0, rd[0]);
        bang_frame(8'h3C, PARITY_EVEN, 1'b0);
        recv_byte(got);
        check_value("m_axis_tdata_o", 8'h3C, got);

        // second frame arrives while the first is still held
        loopback = 1'b1;
        apb_write(REG_CTRL, PARITY_NONE);
        b1 = 8'($urandom() % 256);
        send_byte(b1);
        send_byte(~b1);
        wait_tx_idle();
        check_value("m_axis_tvalid_o", 1, m_axis_tvalid_o);
        check_value("m_axis_tdata_o", b1, m_axis_tdata_o);
        apb_read(REG_STATUS, rd);
        check_value("STATUS[2] rx_valid", 1, rd[2]);
        recv_byte(got);
        check_value("m_axis_tdata_o", b1, got);
        expect_quiet(2 * 10 * DIV_TEST);

        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs + proto_errs + timeout_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/uart_pkg.sv
logic/uart_apb_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
sim/uart_tb.sv
